// File: list.f
common/sd_pkg.sv
src/sd_arbiter.sv
backup/bk_sequencer.sv
backup/bk_ram.sv
msu/msu_data_fetch.sv
src/snes_storage.sv
dv/tb_snes_storage.sv

// File: Bender.yml
package:
  name: snes_storage

sources:
  - common/sd_pkg.sv
  - src/sd_arbiter.sv
  - backup/bk_sequencer.sv
  - backup/bk_ram.sv
  - msu/msu_data_fetch.sv
  - src/snes_storage.sv
  - target: simulation
    files:
      - dv/tb_snes_storage.sv

// File: dv/tb_snes_storage.sv
`timescale 1ns/1ps

module tb_snes_storage;
	import sd_pkg::*;

	localparam int BSRAM_BITS   = 17;
	localparam int DISK_SECTORS = 64;
	localparam int DISK_WORDS   = DISK_SECTORS * SECTOR_WORDS;
	// MSU data file lives from this sector up
	localparam int MSU_FIRST    = 8;
	// four walks and six fills of about 260 cycles each
	// plus 4 KB of CPU traffic come to about 10k cycles
	localparam int CYCLE_LIMIT  = 20000;

	logic        clk_sys;
	logic        reset;
	sd_req_t     host_req;
	logic        host_ack;
	sd_buf_t     host_buf;
	sd_word_t    host_din;
	logic [3:0]  ram_size;
	logic        img_mounted;
	logic        img_readonly;
	logic        osd_status;
	logic        autosave;
	logic        bk_load;
	logic        bk_save;
	logic        bk_loading;
	logic        led_unsaved;
	logic [BSRAM_BITS-1:0] bsram_addr;
	logic [7:0]  bsram_d;
	logic        bsram_we;
	logic [7:0]  bsram_q;
	logic [31:0] msu_addr;
	logic        msu_busy;
	logic [7:0]  msu_data;

	// host disk image with one word per 16-bit buffer slot
	sd_word_t   disk_mem [0:DISK_WORDS-1];
	// what the first 2 KB of backup RAM should hold
	logic [7:0] ram_model [0:2047];
	// requests the host took in arrival order
	sd_lba_t    log_lba [$];
	logic       log_wr [$];
	int         sectors_done;
	integer     seed = 32'h2a77_69df;
	int         cycle_count;
	int         check_count;
	int         error_count;
	int         test_count;
	int         tests_with_errors;
	int         errors_at_start;
	string      cur_test;
	sd_lba_t    msu_cached;

	snes_storage #(.BSRAM_BITS(BSRAM_BITS)) UUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.host_req     (host_req),
		.host_ack     (host_ack),
		.host_buf     (host_buf),
		.host_din     (host_din),
		.ram_size     (ram_size),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.osd_status   (osd_status),
		.autosave     (autosave),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.bk_loading   (bk_loading),
		.led_unsaved  (led_unsaved),
		.bsram_addr   (bsram_addr),
		.bsram_d      (bsram_d),
		.bsram_we     (bsram_we),
		.bsram_q      (bsram_q),
		.msu_addr     (msu_addr),
		.msu_busy     (msu_busy),
		.msu_data     (msu_data)
	);

	// ======================================================================
	// clock and cycle limit
	// ======================================================================

	initial begin
		clk_sys = 1'b0;
		forever begin
			#2 clk_sys = ~clk_sys;
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("timeout: run stopped after %0d cycles during %s",
			cycle_count, cur_test);
		$display("test failed");
		$finish;
	end

	// ======================================================================
	// reference and checking
	// ======================================================================

	// disk byte at a byte address with the even byte in the low half
	function automatic logic [7:0] ref_byte(input logic [31:0] addr);
		sd_word_t w;
		w = disk_mem[addr >> 1];
		return addr[0] ? w[15:8] : w[7:0];
	endfunction

	// sector word a save should produce from the RAM model
	function automatic sd_word_t expected_word(input int idx);
		return {ram_model[2*idx+1], ram_model[2*idx]};
	endfunction

	task automatic check_val(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("error %s %s: expected %h, actual %h",
				cur_test, what, expected, actual);
		end
	endtask

	task automatic report_problem(input string text);
		error_count++;
		$display("%s: %s", cur_test, text);
	endtask

	task automatic start_test(input string name);
		cur_test        = name;
		errors_at_start = error_count;
		test_count++;
		log_lba.delete();
		log_wr.delete();
	endtask

	task automatic finish_test();
		int n;
		n = error_count - errors_at_start;
		if (n == 0) begin
			$display("%s: ok", cur_test);
		end else begin
			tests_with_errors++;
			$display("%s: %0d errors", cur_test, n);
		end
	endtask

	// ======================================================================
	// host block device model
	// ======================================================================

	// take one request, move one sector, drop ack
	task automatic serve_sector();
		sd_lba_t lba;
		logic    is_wr;
		logic    in_range;
		int      delay;
		int      base;
		int      i;
		@(negedge clk_sys);
		while (!(host_req.rd | host_req.wr)) begin
			@(negedge clk_sys);
		end
		lba   = host_req.lba;
		is_wr = host_req.wr;
		log_lba.push_back(lba);
		log_wr.push_back(is_wr);
		in_range = (lba < DISK_SECTORS);
		base     = in_range ? int'(lba) * SECTOR_WORDS : 0;
		if (!in_range) begin
			report_problem("host got a request for a sector past the end of the disk");
		end
		delay = $random(seed) & 7;
		repeat (delay) @(negedge clk_sys);
		host_ack = 1'b1;
		if (is_wr) begin
			// RAM read is registered so the word shows up a cycle after addr
			host_buf.wr   = 1'b0;
			host_buf.addr = '0;
			for (i = 0; i < SECTOR_WORDS; i++) begin
				@(negedge clk_sys);
				if (in_range) begin
					disk_mem[base + i] = host_din;
				end
				host_buf.addr = 8'(i + 1);
			end
		end else begin
			for (i = 0; i < SECTOR_WORDS; i++) begin
				host_buf.addr = 8'(i);
				host_buf.data = in_range ? disk_mem[base + i] : '0;
				host_buf.wr   = 1'b1;
				@(negedge clk_sys);
			end
			host_buf.wr = 1'b0;
		end
		host_ack      = 1'b0;
		host_buf.addr = '0;
		sectors_done++;
	endtask

	initial begin
		host_ack     = 1'b0;
		host_buf     = '0;
		sectors_done = 0;
		forever begin
			serve_sector();
		end
	end

	// ======================================================================
	// stimulus helpers called on a falling edge
	// ======================================================================

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic wait_sectors(input int n);
		while (sectors_done < n) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic pulse_mount();
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic pulse_trigger(input logic load);
		bk_load = load;
		bk_save = ~load;
		@(negedge clk_sys);
		bk_load = 1'b0;
		bk_save = 1'b0;
	endtask

	task automatic cpu_write(input int addr, input logic [7:0] data);
		bsram_addr = addr[BSRAM_BITS-1:0];
		bsram_d    = data;
		bsram_we   = 1'b1;
		ram_model[addr] = data;
		@(negedge clk_sys);
		bsram_we = 1'b0;
	endtask

	// one cycle read latency
	task automatic cpu_read_check(input int addr);
		bsram_addr = addr[BSRAM_BITS-1:0];
		@(negedge clk_sys);
		check_val("cpu read byte", ref_byte(addr), bsram_q);
		ram_model[addr] = ref_byte(addr);
	endtask

	// four sectors from 0 up in one direction
	task automatic check_walk(input int first, input logic is_wr);
		int k;
		if (log_lba.size() < first + 4) begin
			report_problem("walk did not cover all four sectors");
		end else begin
			for (k = 0; k < 4; k++) begin
				check_val("walk lba", k, log_lba[first + k]);
				check_val("walk direction", is_wr, log_wr[first + k]);
			end
		end
	endtask

	task automatic check_saved();
		int i;
		for (i = 0; i < 1024; i++) begin
			check_val("saved disk word", expected_word(i), disk_mem[i]);
		end
	endtask

	// random byte address in a sector other than the cached one
	task automatic pick_msu_addr(output logic [31:0] addr);
		sd_lba_t lba;
		lba = msu_cached;
		while (lba == msu_cached) begin
			lba = MSU_FIRST + ($unsigned($random(seed)) % (DISK_SECTORS - MSU_FIRST));
		end
		addr = (lba << SECTOR_SHIFT) | ($random(seed) & 32'h1ff);
	endtask

	// ======================================================================
	// tests
	// ======================================================================

	initial begin
		logic [31:0] addr;
		logic [7:0]  data;
		int          n0;
		int          a;
		int          k;
		int          j;
		reset        = 1'b1;
		ram_size     = 4'd0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		osd_status   = 1'b0;
		autosave     = 1'b0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		bsram_addr   = '0;
		bsram_d      = '0;
		bsram_we     = 1'b0;
		// cache fill right after reset goes to the first MSU sector
		msu_addr     = MSU_FIRST << SECTOR_SHIFT;
		msu_cached   = MSU_FIRST;
		check_count       = 0;
		error_count       = 0;
		test_count        = 0;
		tests_with_errors = 0;
		cur_test          = "startup";
		for (a = 0; a < DISK_WORDS; a++) begin
			disk_mem[a] = $random(seed);
		end
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		// invalid cache misses once out of reset
		wait_sectors(1);
		while (msu_busy) begin
			@(negedge clk_sys);
		end

		// 2 KB of CPU data saved as sectors 0..3
		start_test("save");
		ram_size     = 4'd1;
		img_readonly = 1'b0;
		pulse_mount();
		for (a = 0; a < 2048; a++) begin
			cpu_write(a, $random(seed));
		end
		n0 = sectors_done;
		pulse_trigger(1'b0);
		wait_sectors(n0 + 4);
		// a fifth sector would show up here
		wait_cycles(20);
		check_val("request count", 4, log_lba.size());
		check_walk(0, 1'b1);
		check_saved();
		finish_test();

		// fresh disk image read back into the RAM
		start_test("load");
		for (a = 0; a < 1024; a++) begin
			disk_mem[a] = $random(seed);
		end
		pulse_trigger(1'b1);
		check_val("bk_loading after trigger", 1, bk_loading);
		while (bk_loading) begin
			@(negedge clk_sys);
		end
		wait_cycles(2);
		check_val("request count", 4, log_lba.size());
		check_walk(0, 1'b0);
		for (a = 0; a < 2048; a++) begin
			cpu_read_check(a);
		end
		finish_test();

		// unsaved flag, autosave on OSD open, then a disabled save file
		start_test("autosave");
		a    = $random(seed) & 11'h7ff;
		data = ~ram_model[a];
		cpu_write(a, data);
		check_val("led_unsaved after write", 1, led_unsaved);
		n0         = sectors_done;
		autosave   = 1'b1;
		osd_status = 1'b1;
		wait_sectors(n0 + 4);
		wait_cycles(20);
		check_val("led_unsaved after save", 0, led_unsaved);
		check_val("request count", 4, log_lba.size());
		check_walk(0, 1'b1);
		check_val("autosaved byte", data, ref_byte(a));
		check_saved();
		osd_status = 1'b0;
		autosave   = 1'b0;
		// ram_size 0 clears bk_ena
		ram_size = 4'd0;
		pulse_mount();
		log_lba.delete();
		log_wr.delete();
		cpu_write(a ^ 1, $random(seed));
		autosave   = 1'b1;
		osd_status = 1'b1;
		pulse_trigger(1'b0);
		wait_cycles(50);
		check_val("requests with save disabled", 0, log_lba.size());
		osd_status = 1'b0;
		autosave   = 1'b0;
		ram_size   = 4'd1;
		pulse_mount();
		finish_test();

		// misses fill the cache while hits stay quiet
		start_test("msu_fetch");
		for (k = 0; k < 4; k++) begin
			pick_msu_addr(addr);
			n0       = log_lba.size();
			msu_addr = addr;
			j        = 0;
			while (!msu_busy && j < 4) begin
				@(negedge clk_sys);
				j++;
			end
			if (!msu_busy) begin
				report_problem("msu_busy did not rise after a miss");
			end
			while (msu_busy) begin
				@(negedge clk_sys);
			end
			check_val("miss request count", n0 + 1, log_lba.size());
			if (log_lba.size() > n0) begin
				check_val("miss lba", addr >> SECTOR_SHIFT, log_lba[n0]);
				check_val("miss direction", 0, log_wr[n0]);
			end
			check_val("msu byte after fill", ref_byte(addr), msu_data);
			msu_cached = addr >> SECTOR_SHIFT;
			n0 = log_lba.size();
			for (j = 0; j < 4; j++) begin
				addr     = (msu_cached << SECTOR_SHIFT) | ($random(seed) & 32'h1ff);
				msu_addr = addr;
				wait_cycles(3);
				check_val("msu_busy on a hit", 0, msu_busy);
				check_val("msu byte on a hit", ref_byte(addr), msu_data);
			end
			check_val("requests on hits", n0, log_lba.size());
		end
		finish_test();

		// save and MSU miss launched together with backup going first
		start_test("arbitration");
		pick_msu_addr(addr);
		n0       = sectors_done;
		bk_save  = 1'b1;
		msu_addr = addr;
		@(negedge clk_sys);
		bk_save = 1'b0;
		wait_sectors(n0 + 5);
		while (msu_busy) begin
			@(negedge clk_sys);
		end
		wait_cycles(20);
		check_val("request count", 5, log_lba.size());
		check_walk(0, 1'b1);
		if (log_lba.size() >= 5) begin
			check_val("msu lba after walk", addr >> SECTOR_SHIFT, log_lba[4]);
			check_val("msu direction", 0, log_wr[4]);
		end
		check_saved();
		check_val("msu byte after walk", ref_byte(addr), msu_data);
		msu_cached = addr >> SECTOR_SHIFT;
		finish_test();

		$display("%0d tests run, %0d with errors, %0d checks, %0d errors",
			test_count, tests_with_errors, check_count, error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: src/snes_storage.sv
`timescale 1ns/1ps

module snes_storage #(
	parameter int BSRAM_BITS = 17
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	output sd_pkg::sd_req_t       host_req,
	input  logic                  host_ack,
	input  sd_pkg::sd_buf_t       host_buf,
	output sd_pkg::sd_word_t      host_din,
	input  logic [3:0]            ram_size,
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic                  osd_status,
	input  logic                  autosave,
	input  logic                  bk_load,
	input  logic                  bk_save,
	output logic                  bk_loading,
	output logic                  led_unsaved,
	input  logic [BSRAM_BITS-1:0] bsram_addr,
	input  logic [7:0]            bsram_d,
	input  logic                  bsram_we,
	output logic [7:0]            bsram_q,
	input  logic [31:0]           msu_addr,
	output logic                  msu_busy,
	output logic [7:0]            msu_data
);
	import sd_pkg::*;

	sd_req_t  bk_req;
	sd_req_t  msu_req;
	logic     bk_ack;
	logic     msu_ack;
	chan_e    arb_grant;
	logic     arb_busy;
	sd_word_t bk_sec_q;
	logic     bk_sec_we;

	// ======================================================================
	// host sector interface sharing
	// ======================================================================

	sd_arbiter u_arbiter (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bk_req   (bk_req),
		.msu_req  (msu_req),
		.host_ack (host_ack),
		.host_req (host_req),
		.bk_ack   (bk_ack),
		.msu_ack  (msu_ack),
		.grant    (arb_grant),
		.busy     (arb_busy)
	);

	// RAM word goes out only during a backup transfer
	assign host_din  = (arb_busy && arb_grant == CH_BACKUP) ? bk_sec_q : '0;
	// load writes into RAM on the backup channel only
	assign bk_sec_we = bk_ack & host_buf.wr;

	// ======================================================================
	// backup RAM and its save/load walk
	// ======================================================================

	bk_sequencer #(.BSRAM_BITS(BSRAM_BITS)) u_bk_seq (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ram_size     (ram_size),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.osd_status   (osd_status),
		.autosave     (autosave),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.cpu_we       (bsram_we),
		.ack          (bk_ack),
		.req          (bk_req),
		.bk_loading   (bk_loading),
		.led_unsaved  (led_unsaved)
	);

	bk_ram #(.BSRAM_BITS(BSRAM_BITS)) u_bk_ram (
		.clk_sys  (clk_sys),
		.cpu_addr (bsram_addr),
		.cpu_d    (bsram_d),
		.cpu_we   (bsram_we),
		.cpu_q    (bsram_q),
		.sec_lba  (bk_req.lba),
		.sec_buf  (host_buf),
		.sec_we   (bk_sec_we),
		.sec_q    (bk_sec_q)
	);

	// ======================================================================
	// MSU data file
	// ======================================================================

	msu_data_fetch u_msu_fetch (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.msu_addr (msu_addr),
		.ack      (msu_ack),
		.sec_buf  (host_buf),
		.req      (msu_req),
		.msu_busy (msu_busy),
		.msu_data (msu_data)
	);

endmodule

// File: msu/msu_data_fetch.sv
`timescale 1ns/1ps

module msu_data_fetch (
	input  logic            clk_sys,
	input  logic            reset,
	input  logic [31:0]     msu_addr,
	input  logic            ack,
	input  sd_pkg::sd_buf_t sec_buf,
	output sd_pkg::sd_req_t req,
	output logic            msu_busy,
	output logic [7:0]      msu_data
);
	import sd_pkg::*;

	// one cached sector of the data file
	sd_word_t cache_mem [0:SECTOR_WORDS-1];
	logic     cache_valid;
	sd_lba_t  cache_lba;
	// sector holding the requested byte
	sd_lba_t  want_lba;
	logic     miss;
	logic     old_ack;
	sd_word_u rd_word;

	assign want_lba = msu_addr >> SECTOR_SHIFT;
	assign miss     = ~cache_valid | (want_lba != cache_lba);

	// ======================================================================
	// miss handling and fill
	// ======================================================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			req         <= '0;
			msu_busy    <= 1'b0;
			cache_valid <= 1'b0;
			cache_lba   <= '0;
			old_ack     <= 1'b0;
		end else begin
			old_ack <= ack;
			if (!msu_busy) begin
				if (miss) begin
					// launch a read of the wanted sector
					req.lba     <= want_lba;
					req.rd      <= 1'b1;
					req.wr      <= 1'b0;
					msu_busy    <= 1'b1;
					cache_lba   <= want_lba;
					cache_valid <= 1'b0;
				end
			end else begin
				// host has it, drop the level
				if (ack & ~old_ack) begin
					req.rd <= 1'b0;
				end
				// fill done
				if (~ack & old_ack) begin
					msu_busy    <= 1'b0;
					cache_valid <= 1'b1;
				end
			end
		end
	end

	// words land only while our ack is up
	always_ff @(posedge clk_sys) begin
		if (ack & sec_buf.wr) begin
			cache_mem[sec_buf.addr] <= sec_buf.data;
		end
	end

	// ======================================================================
	// byte read
	// ======================================================================

	// addr bits 8:1 pick the word, bit 0 the half
	assign rd_word.word = cache_mem[msu_addr[8:1]];
	assign msu_data     = msu_addr[0] ? rd_word.b.hi : rd_word.b.lo;

endmodule

// File: backup/bk_ram.sv
`timescale 1ns/1ps

module bk_ram #(
	parameter int BSRAM_BITS = 17
) (
	input  logic                  clk_sys,
	input  logic [BSRAM_BITS-1:0] cpu_addr,
	input  logic [7:0]            cpu_d,
	input  logic                  cpu_we,
	output logic [7:0]            cpu_q,
	input  sd_pkg::sd_lba_t       sec_lba,
	input  sd_pkg::sd_buf_t       sec_buf,
	input  logic                  sec_we,
	output sd_pkg::sd_word_t      sec_q
);
	import sd_pkg::*;

	localparam int WORD_BITS = BSRAM_BITS - 1;

	// even bytes in lo bank, odd bytes in hi bank
	logic [7:0] lo_bank [0:2**WORD_BITS-1];
	logic [7:0] hi_bank [0:2**WORD_BITS-1];

	logic [WORD_BITS-1:0] cpu_word;
	logic [WORD_BITS-1:0] sec_word;
	logic                 cpu_odd;
	logic [7:0]           cpu_lo_q;
	logic [7:0]           cpu_hi_q;
	sd_word_u             wr_word;
	sd_word_u             rd_word;

	assign cpu_word     = cpu_addr[BSRAM_BITS-1:1];
	// low lba bits select the sector, buffer addr the word
	assign sec_word     = {sec_lba[BSRAM_BITS-10:0], sec_buf.addr};
	assign wr_word.word = sec_buf.data;

	// byte port and word port, both read registered
	always_ff @(posedge clk_sys) begin
		if (cpu_we & ~cpu_addr[0]) begin
			lo_bank[cpu_word] <= cpu_d;
		end
		if (cpu_we & cpu_addr[0]) begin
			hi_bank[cpu_word] <= cpu_d;
		end
		if (sec_we) begin
			lo_bank[sec_word] <= wr_word.b.lo;
			hi_bank[sec_word] <= wr_word.b.hi;
		end
		cpu_lo_q     <= lo_bank[cpu_word];
		cpu_hi_q     <= hi_bank[cpu_word];
		cpu_odd      <= cpu_addr[0];
		rd_word.b.lo <= lo_bank[sec_word];
		rd_word.b.hi <= hi_bank[sec_word];
	end

	assign cpu_q = cpu_odd ? cpu_hi_q : cpu_lo_q;
	assign sec_q = rd_word.word;

endmodule

// File: backup/bk_sequencer.sv
`timescale 1ns/1ps

module bk_sequencer #(
	parameter int BSRAM_BITS = 17
) (
	input  logic            clk_sys,
	input  logic            reset,
	input  logic [3:0]      ram_size,
	input  logic            img_mounted,
	input  logic            img_readonly,
	input  logic            osd_status,
	input  logic            autosave,
	input  logic            bk_load,
	input  logic            bk_save,
	input  logic            cpu_we,
	input  logic            ack,
	output sd_pkg::sd_req_t req,
	output logic            bk_loading,
	output logic            led_unsaved
);
	import sd_pkg::*;

	// highest sector the backup RAM can hold
	localparam sd_lba_t RAM_LAST = (32'd1 << (BSRAM_BITS - SECTOR_SHIFT)) - 32'd1;

	logic    bk_ena;
	logic    walking;
	logic    old_load;
	logic    old_save;
	logic    old_auto;
	logic    old_ack;
	logic    auto_req;
	logic    load_rise;
	logic    save_rise;
	logic    auto_rise;
	logic    start;
	sd_lba_t size_last;
	sd_lba_t end_lba;

	// 1 KB << ram_size bytes, i.e. 2 << ram_size sectors
	assign size_last = (sd_lba_t'(2) << ram_size) - 32'd1;
	// clamp to what is really there
	assign end_lba   = (size_last > RAM_LAST) ? RAM_LAST : size_last;

	// ======================================================================
	// triggers
	// ======================================================================

	// autosave once the OSD opens with unsaved data
	assign auto_req  = led_unsaved & osd_status & autosave;
	assign load_rise = bk_load & ~old_load;
	assign save_rise = bk_save & ~old_save;
	assign auto_rise = auto_req & ~old_auto;
	assign start     = bk_ena & ~walking & (load_rise | save_rise | auto_rise);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_auto <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_auto <= auto_req;
			old_ack  <= ack;
		end
	end

	// save file usable only if writable and cart has RAM
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			bk_ena <= 1'b0;
		end else if (img_mounted) begin
			bk_ena <= ~img_readonly & (ram_size != 4'd0);
		end
	end

	// unsaved flag, CPU writes count only with the OSD closed
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			led_unsaved <= 1'b0;
		end else if (cpu_we & ~osd_status) begin
			led_unsaved <= 1'b1;
		end else if (start) begin
			led_unsaved <= 1'b0;
		end
	end

	// ======================================================================
	// sector walk 0 .. end_lba
	// ======================================================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			req        <= '0;
			walking    <= 1'b0;
			bk_loading <= 1'b0;
		end else if (!walking) begin
			if (start) begin
				// load wins over save on the same edge
				walking    <= 1'b1;
				bk_loading <= load_rise;
				req.lba    <= '0;
				req.rd     <= load_rise;
				req.wr     <= ~load_rise;
			end
		end else begin
			// host took the request
			if (ack & ~old_ack) begin
				req.rd <= 1'b0;
				req.wr <= 1'b0;
			end
			// sector done, next one or finish
			if (~ack & old_ack) begin
				if (req.lba >= end_lba) begin
					walking    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					req.lba <= req.lba + 32'd1;
					req.rd  <= bk_loading;
					req.wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

// File: src/sd_arbiter.sv
`timescale 1ns/1ps

module sd_arbiter (
	input  logic            clk_sys,
	input  logic            reset,
	input  sd_pkg::sd_req_t bk_req,
	input  sd_pkg::sd_req_t msu_req,
	input  logic            host_ack,
	output sd_pkg::sd_req_t host_req,
	output logic            bk_ack,
	output logic            msu_ack,
	output sd_pkg::chan_e   grant,
	output logic            busy
);
	import sd_pkg::*;

	// channel has rd or wr up
	logic bk_want;
	logic msu_want;
	// host ack seen high during this grant
	logic ack_seen;

	assign bk_want  = bk_req.rd | bk_req.wr;
	assign msu_want = msu_req.rd | msu_req.wr;

	// ======================================================================
	// grant machine
	// ======================================================================

	// idle -> granted on any request, backup first
	// granted -> idle once ack has gone high and back low
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			busy     <= 1'b0;
			grant    <= CH_BACKUP;
			ack_seen <= 1'b0;
		end else if (!busy) begin
			ack_seen <= 1'b0;
			if (bk_want) begin
				grant <= CH_BACKUP;
				busy  <= 1'b1;
			end else if (msu_want) begin
				grant <= CH_MSU;
				busy  <= 1'b1;
			end
		end else begin
			if (host_ack) begin
				ack_seen <= 1'b1;
			end else if (ack_seen) begin
				// transfer over, one idle cycle follows
				busy <= 1'b0;
			end
		end
	end

	// ======================================================================
	// request and ack routing
	// ======================================================================

	// nothing goes to the host while idle
	always_comb begin
		host_req = '0;
		if (busy) begin
			if (grant == CH_BACKUP) begin
				host_req = bk_req;
			end else begin
				host_req = msu_req;
			end
		end
	end

	// ack only reaches the channel holding the grant
	assign bk_ack  = host_ack & busy & (grant == CH_BACKUP);
	assign msu_ack = host_ack & busy & (grant == CH_MSU);

endmodule

// File: common/sd_pkg.sv
package sd_pkg;

	// ======================================================================
	// sector geometry
	// ======================================================================

	// words per 512-byte sector
	localparam int SECTOR_WORDS = 256;
	// byte address bits inside one sector
	localparam int SECTOR_SHIFT = 9;

	// one host buffer word
	typedef logic [15:0] sd_word_t;

	// host sector number
	typedef logic [31:0] sd_lba_t;

	// ======================================================================
	// channels sharing the host sector interface
	// ======================================================================

	// lower value wins a tie
	typedef enum logic {
		CH_BACKUP = 1'b0,
		CH_MSU    = 1'b1
	} chan_e;

	// sector request, held as a level until ack rises
	typedef struct packed {
		sd_lba_t lba;
		logic    rd;
		logic    wr;
	} sd_req_t;

	// host to design buffer bus
	// wr pulses once per word on a sector read
	typedef struct packed {
		logic [7:0] addr;
		sd_word_t   data;
		logic       wr;
	} sd_buf_t;

	// ======================================================================
	// byte view of a buffer word
	// ======================================================================

	// lo is the even byte address, hi the odd one
	typedef union packed {
		sd_word_t word;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} b;
	} sd_word_u;

endpackage
